/* common/kbest_consts.svh */
`ifndef KBEST_CONSTS_SVH
`define KBEST_CONSTS_SVH

// datapath widths
`define KB_SAMPLE_W   16
`define KB_COEF_W     16
`define KB_ERR_W      24
`define KB_PED_W      32

// tree shape of one detection step
`define KB_N_PARENT   4
`define KB_N_CAND     4
`define KB_N_LEVEL    8
`define KB_N_SURV     8

// wishbone word address width
`define KB_ADR_W      6

// register map, word addresses
`define KB_ADR_CTRL   0
`define KB_ADR_Y1     1
`define KB_ADR_Y2     2
`define KB_ADR_R11    3
`define KB_ADR_R22    4
// three words per parent: ped, isum_hi, isum_lo
`define KB_ADR_PARENT 8
// two words per survivor: ped, info
`define KB_ADR_RESULT 32

`endif

/* common/kbest_pkg.sv */
`include "kbest_consts.svh"

package kbest_pkg;

  // signed datapath values
  typedef logic signed [`KB_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`KB_COEF_W-1:0]   coef_t;
  typedef logic signed [`KB_ERR_W-1:0]    err_t;
  // accumulated distance, never negative
  typedef logic [`KB_PED_W-1:0]           ped_t;

  // 8-pam code c maps to level 2c-7
  typedef logic [2:0] level_code_t;
  typedef logic [1:0] parent_idx_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`KB_ADR_W-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // parent path with interference sums already formed
  typedef struct packed {
    ped_t    ped;
    sample_t isum_hi;
    sample_t isum_lo;
  } parent_t;

  typedef struct packed {
    level_code_t code;
    err_t        err;
  } cand_t;

  typedef struct packed {
    ped_t        ped;
    parent_idx_t parent;
    level_code_t code_hi;
    level_code_t code_lo;
  } child_t;

  typedef enum logic [1:0] {
    IDLE,
    SLICE,
    ISSUE,
    DRAIN
  } ctrl_state_e;

endpackage

/* hdl/kbest_ctrl.sv */
`timescale 1ns/1ps
`include "kbest_consts.svh"

module kbest_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  kbest_pkg::wb_req_t     wb_i,
  output kbest_pkg::wb_rsp_t     wb_o,
  output kbest_pkg::sample_t     y1,
  output kbest_pkg::sample_t     y2,
  output kbest_pkg::coef_t       r11,
  output kbest_pkg::coef_t       r22,
  output kbest_pkg::parent_t     parent,
  output logic                   slice,
  output logic                   child_valid,
  output logic [1:0]             rank_hi,
  output logic [1:0]             rank_lo,
  output kbest_pkg::parent_idx_t parent_idx,
  output logic                   sort_clear,
  input  kbest_pkg::child_t      surv_list [`KB_N_SURV]
);

  kbest_pkg::ctrl_state_e state;
  kbest_pkg::parent_t     par_q [`KB_N_PARENT];
  kbest_pkg::parent_idx_t par_cnt;
  // m in the upper two bits, i in the lower two
  logic [3:0]             child_cnt;
  logic                   drain_cnt;
  logic                   busy;
  logic                   done;
  logic                   ack_q;
  logic [31:0]            rd_data;
  logic [31:0]            rd_q;
  logic                   bus_req;
  logic                   wr_req;
  logic                   cfg_wr;
  logic                   start;

  assign bus_req = wb_i.cyc & wb_i.stb;
  assign wr_req  = bus_req & wb_i.we;
  assign busy    = (state != kbest_pkg::IDLE);
  // config frozen while a run is going
  assign cfg_wr  = wr_req & ~busy;
  // start ignored while busy
  assign start   = cfg_wr & (wb_i.adr == `KB_ADR_CTRL) & wb_i.dat[0];

  // zero wait states, ack on the edge after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_req && !wb_i.we) begin
      rd_q <= rd_data;
    end
  end

  assign wb_o = '{ack: ack_q, dat: rd_q};

  // configuration and parent registers
  always_ff @(posedge clk) begin
    if (cfg_wr) begin
      case (wb_i.adr)
        `KB_ADR_Y1:  y1  <= kbest_pkg::sample_t'(wb_i.dat);
        `KB_ADR_Y2:  y2  <= kbest_pkg::sample_t'(wb_i.dat);
        `KB_ADR_R11: r11 <= kbest_pkg::coef_t'(wb_i.dat);
        `KB_ADR_R22: r22 <= kbest_pkg::coef_t'(wb_i.dat);
        default: ;
      endcase
      for (int p = 0; p < `KB_N_PARENT; p++) begin
        if (wb_i.adr == `KB_ADR_PARENT + 3 * p)
          par_q[p].ped <= wb_i.dat;
        if (wb_i.adr == `KB_ADR_PARENT + 3 * p + 1)
          par_q[p].isum_hi <= kbest_pkg::sample_t'(wb_i.dat);
        if (wb_i.adr == `KB_ADR_PARENT + 3 * p + 2)
          par_q[p].isum_lo <= kbest_pkg::sample_t'(wb_i.dat);
      end
    end
  end

  // readback mux, unmapped words give zero
  always_comb begin
    rd_data = '0;
    case (wb_i.adr)
      `KB_ADR_CTRL: rd_data = {30'b0, done, busy};
      `KB_ADR_Y1:   rd_data = 32'(y1);
      `KB_ADR_Y2:   rd_data = 32'(y2);
      `KB_ADR_R11:  rd_data = 32'(r11);
      `KB_ADR_R22:  rd_data = 32'(r22);
      default: ;
    endcase
    for (int p = 0; p < `KB_N_PARENT; p++) begin
      if (wb_i.adr == `KB_ADR_PARENT + 3 * p)
        rd_data = par_q[p].ped;
      if (wb_i.adr == `KB_ADR_PARENT + 3 * p + 1)
        rd_data = 32'(par_q[p].isum_hi);
      if (wb_i.adr == `KB_ADR_PARENT + 3 * p + 2)
        rd_data = 32'(par_q[p].isum_lo);
    end
    // info word packs parent, code_hi, code_lo from bit 7 down
    for (int s = 0; s < `KB_N_SURV; s++) begin
      if (wb_i.adr == `KB_ADR_RESULT + 2 * s)
        rd_data = surv_list[s].ped;
      if (wb_i.adr == `KB_ADR_RESULT + 2 * s + 1)
        rd_data = 32'({surv_list[s].parent, surv_list[s].code_hi, surv_list[s].code_lo});
    end
  end

  // sequencer: per parent one slice then 16 issues, two drain cycles at the end
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= kbest_pkg::IDLE;
      par_cnt    <= '0;
      child_cnt  <= '0;
      drain_cnt  <= 1'b0;
      done       <= 1'b0;
      sort_clear <= 1'b0;
    end else begin
      sort_clear <= start;
      case (state)
        kbest_pkg::IDLE: begin
          if (start) begin
            state     <= kbest_pkg::SLICE;
            par_cnt   <= '0;
            child_cnt <= '0;
            done      <= 1'b0;
          end
        end
        kbest_pkg::SLICE: begin
          state <= kbest_pkg::ISSUE;
        end
        kbest_pkg::ISSUE: begin
          child_cnt <= child_cnt + 4'd1;
          if (child_cnt == 4'd15) begin
            if (par_cnt == kbest_pkg::parent_idx_t'(`KB_N_PARENT - 1)) begin
              state     <= kbest_pkg::DRAIN;
              drain_cnt <= 1'b0;
            end else begin
              par_cnt <= par_cnt + 2'd1;
              state   <= kbest_pkg::SLICE;
            end
          end
        end
        kbest_pkg::DRAIN: begin
          // last child leaves ped_calc, then lands in the list
          drain_cnt <= 1'b1;
          if (drain_cnt) begin
            state <= kbest_pkg::IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= kbest_pkg::IDLE;
      endcase
    end
  end

  assign slice       = (state == kbest_pkg::SLICE);
  assign child_valid = (state == kbest_pkg::ISSUE);
  assign rank_hi     = child_cnt[3:2];
  assign rank_lo     = child_cnt[1:0];
  assign parent_idx  = par_cnt;
  assign parent      = par_q[par_cnt];

  // master must drop stb after each ack
  a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_o.ack |=> !wb_o.ack);

endmodule

/* hdl/kbest_layer_top.sv */
`timescale 1ns/1ps
`include "kbest_consts.svh"

module kbest_layer_top (
  input  logic               clk,
  input  logic               rst,
  input  kbest_pkg::wb_req_t wb_i,
  output kbest_pkg::wb_rsp_t wb_o
);

  // configuration from the register file
  kbest_pkg::sample_t     y1;
  kbest_pkg::sample_t     y2;
  kbest_pkg::coef_t       r11;
  kbest_pkg::coef_t       r22;
  kbest_pkg::parent_t     parent;

  // sequencing
  logic                   slice;
  logic                   child_valid;
  logic [1:0]             rank_hi;
  logic [1:0]             rank_lo;
  kbest_pkg::parent_idx_t parent_idx;
  logic                   sort_clear;

  // ranked candidates per row
  kbest_pkg::cand_t       cand_hi [`KB_N_CAND];
  kbest_pkg::cand_t       cand_lo [`KB_N_CAND];

  // child stream and survivor list
  kbest_pkg::child_t      child;
  logic                   child_out_valid;
  kbest_pkg::child_t      surv_list [`KB_N_SURV];

  kbest_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .y1          (y1),
    .y2          (y2),
    .r11         (r11),
    .r22         (r22),
    .parent      (parent),
    .slice       (slice),
    .child_valid (child_valid),
    .rank_hi     (rank_hi),
    .rank_lo     (rank_lo),
    .parent_idx  (parent_idx),
    .sort_clear  (sort_clear),
    .surv_list   (surv_list)
  );

  // upper row, y1 against R11
  symbol_slicer slicer_hi (
    .clk   (clk),
    .rst   (rst),
    .slice (slice),
    .y     (y1),
    .isum  (parent.isum_hi),
    .coef  (r11),
    .cand  (cand_hi)
  );

  // lower row, y2 against R22
  symbol_slicer slicer_lo (
    .clk   (clk),
    .rst   (rst),
    .slice (slice),
    .y     (y2),
    .isum  (parent.isum_lo),
    .coef  (r22),
    .cand  (cand_lo)
  );

  ped_calc u_ped_calc (
    .clk             (clk),
    .rst             (rst),
    .child_valid     (child_valid),
    .rank_hi         (rank_hi),
    .rank_lo         (rank_lo),
    .parent_idx      (parent_idx),
    .parent_ped      (parent.ped),
    .cand_hi         (cand_hi),
    .cand_lo         (cand_lo),
    .child           (child),
    .child_out_valid (child_out_valid)
  );

  survivor_sorter u_sorter (
    .clk         (clk),
    .rst         (rst),
    .clear       (sort_clear),
    .child       (child),
    .child_valid (child_out_valid),
    .surv_list   (surv_list)
  );

endmodule

/* hdl/ped_calc.sv */
`timescale 1ns/1ps
`include "kbest_consts.svh"

module ped_calc (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   child_valid,
  input  logic [1:0]             rank_hi,
  input  logic [1:0]             rank_lo,
  input  kbest_pkg::parent_idx_t parent_idx,
  input  kbest_pkg::ped_t        parent_ped,
  input  kbest_pkg::cand_t       cand_hi [`KB_N_CAND],
  input  kbest_pkg::cand_t       cand_lo [`KB_N_CAND],
  output kbest_pkg::child_t      child,
  output logic                   child_out_valid
);

  kbest_pkg::cand_t                sel_hi;
  kbest_pkg::cand_t                sel_lo;
  // full-width products before trimming to the ped width
  logic signed [2*`KB_ERR_W-1:0]   prod_hi;
  logic signed [2*`KB_ERR_W-1:0]   prod_lo;
  kbest_pkg::ped_t                 ped_sum;

  // m picks from the upper row, i from the lower row
  assign sel_hi  = cand_hi[rank_hi];
  assign sel_lo  = cand_lo[rank_lo];
  assign prod_hi = sel_hi.err * sel_hi.err;
  assign prod_lo = sel_lo.err * sel_lo.err;
  assign ped_sum = parent_ped + prod_hi[`KB_PED_W-1:0] + prod_lo[`KB_PED_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      child_out_valid <= 1'b0;
    end else begin
      child_out_valid <= child_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (child_valid) begin
      child <= '{ped: ped_sum, parent: parent_idx, code_hi: sel_hi.code, code_lo: sel_lo.code};
    end
  end

endmodule

/* hdl/symbol_slicer.sv */
`timescale 1ns/1ps
`include "kbest_consts.svh"

module symbol_slicer (
  input  logic               clk,
  input  logic               rst,
  input  logic               slice,
  input  kbest_pkg::sample_t y,
  input  kbest_pkg::sample_t isum,
  input  kbest_pkg::coef_t   coef,
  output kbest_pkg::cand_t   cand [`KB_N_CAND]
);

  kbest_pkg::err_t  resid;
  kbest_pkg::err_t  err [`KB_N_LEVEL];
  kbest_pkg::err_t  mag [`KB_N_LEVEL];
  logic [2:0]       rank [`KB_N_LEVEL];
  kbest_pkg::cand_t cand_nxt [`KB_N_CAND];
  logic             codes_distinct;

  // residual once interference of upper layers is removed
  assign resid = kbest_pkg::err_t'(y) - kbest_pkg::err_t'(isum);

  always_comb begin
    for (int c = 0; c < `KB_N_LEVEL; c++) begin
      // level 2c-7 scaled by the diagonal
      err[c] = resid - kbest_pkg::err_t'(coef * (2 * c - 7));
      mag[c] = (err[c] < 0) ? -err[c] : err[c];
    end
    // rank = count of levels that beat this one, lower code wins a tie
    for (int c = 0; c < `KB_N_LEVEL; c++) begin
      rank[c] = '0;
      for (int d = 0; d < `KB_N_LEVEL; d++) begin
        if (mag[d] < mag[c] || (mag[d] == mag[c] && d < c))
          rank[c] = rank[c] + 3'd1;
      end
    end
    for (int r = 0; r < `KB_N_CAND; r++) begin
      cand_nxt[r] = '0;
    end
    // ranks are a permutation, so each kept slot gets one writer
    for (int c = 0; c < `KB_N_LEVEL; c++) begin
      if (rank[c] < `KB_N_CAND)
        cand_nxt[rank[c][1:0]] = '{code: kbest_pkg::level_code_t'(c), err: err[c]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `KB_N_CAND; r++) begin
        cand[r] <= '0;
      end
    end else if (slice) begin
      cand <= cand_nxt;
    end
  end

  always_comb begin
    codes_distinct = 1'b1;
    for (int a = 0; a < `KB_N_CAND; a++) begin
      for (int b = a + 1; b < `KB_N_CAND; b++) begin
        if (cand[a].code == cand[b].code)
          codes_distinct = 1'b0;
      end
    end
  end

  // every slice leaves four different levels behind
  a_codes_distinct: assert property (@(posedge clk) disable iff (rst) slice |=> codes_distinct);

endmodule

/* list.f */
+incdir+common
+incdir+verification
common/kbest_pkg.sv
hdl/symbol_slicer.sv
hdl/ped_calc.sv
survivor_sort/survivor_sorter.sv
hdl/kbest_ctrl.sv
hdl/kbest_layer_top.sv
verification/kbest_tb.sv

/* survivor_sort/survivor_sorter.sv */
`timescale 1ns/1ps
`include "kbest_consts.svh"

module survivor_sorter (
  input  logic              clk,
  input  logic              rst,
  input  logic              clear,
  input  kbest_pkg::child_t child,
  input  logic              child_valid,
  output kbest_pkg::child_t surv_list [`KB_N_SURV]
);

  // empty slot marker, sorts after any real child
  localparam kbest_pkg::child_t EMPTY = '{ped: '1, default: '0};

  kbest_pkg::child_t     ent [`KB_N_SURV];
  kbest_pkg::child_t     ent_nxt [`KB_N_SURV];
  logic [`KB_N_SURV-1:0] gt;
  logic                  sorted;

  always_comb begin
    // strict compare keeps equal peds in arrival order
    for (int k = 0; k < `KB_N_SURV; k++) begin
      gt[k] = ent[k].ped > child.ped;
    end
    // gt is 0..0 1..1 over a sorted list, first 1 is the insert slot
    ent_nxt[0] = gt[0] ? child : ent[0];
    for (int k = 1; k < `KB_N_SURV; k++) begin
      if (!gt[k])
        ent_nxt[k] = ent[k];
      else if (gt[k-1])
        ent_nxt[k] = ent[k-1];
      else
        ent_nxt[k] = child;
    end
  end

  // last entry falls off the end when a better child arrives
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      for (int k = 0; k < `KB_N_SURV; k++) begin
        ent[k] <= EMPTY;
      end
    end else if (child_valid) begin
      ent <= ent_nxt;
    end
  end

  // empty slots read back as zero
  always_comb begin
    for (int k = 0; k < `KB_N_SURV; k++) begin
      if (ent[k].ped == EMPTY.ped)
        surv_list[k] = '0;
      else
        surv_list[k] = ent[k];
    end
  end

  always_comb begin
    sorted = 1'b1;
    for (int k = 0; k + 1 < `KB_N_SURV; k++) begin
      if (ent[k].ped > ent[k+1].ped)
        sorted = 1'b0;
    end
  end

  // list stays in ascending ped order through every insertion
  a_list_sorted: assert property (@(posedge clk) disable iff (rst) sorted);

endmodule

/* verification/kbest_ref_model.svh */
`ifndef KBEST_REF_MODEL_SVH
`define KBEST_REF_MODEL_SVH

// ranked candidates, row 0 is y1/R11, row 1 is y2/R22
int     mdl_code [2][`KB_N_CAND];
int     mdl_err  [2][`KB_N_CAND];
// expected survivor list, best first
longint exp_ped  [`KB_N_SURV];
int     exp_info [`KB_N_SURV];
int     exp_n;

// four nearest 8-pam levels by absolute error, ties to the lower code
function automatic void slice_row(input int row, input int resid, input int coef);
  int mag  [`KB_N_LEVEL];
  bit used [`KB_N_LEVEL];
  int best;
  for (int c = 0; c < `KB_N_LEVEL; c++) begin
    mag[c] = resid - coef * (2 * c - 7);
    if (mag[c] < 0)
      mag[c] = -mag[c];
    used[c] = 1'b0;
  end
  // smallest unused level, strict compare keeps the lower code
  for (int r = 0; r < `KB_N_CAND; r++) begin
    best = -1;
    for (int c = 0; c < `KB_N_LEVEL; c++) begin
      if (!used[c] && (best < 0 || mag[c] < mag[best]))
        best = c;
    end
    used[best]       = 1'b1;
    mdl_code[row][r] = best;
    mdl_err[row][r]  = resid - coef * (2 * best - 7);
  end
endfunction

// stable insert, new child lands after every equal ped
function automatic void insert_child(input longint ped, input int info);
  int pos;
  pos = exp_n;
  for (int k = exp_n - 1; k >= 0; k--) begin
    if (exp_ped[k] > ped)
      pos = k;
  end
  if (pos < `KB_N_SURV) begin
    for (int k = `KB_N_SURV - 1; k > pos; k--) begin
      exp_ped[k]  = exp_ped[k-1];
      exp_info[k] = exp_info[k-1];
    end
    exp_ped[pos]  = ped;
    exp_info[pos] = info;
    if (exp_n < `KB_N_SURV)
      exp_n++;
  end
endfunction

// parents in index order, m outer and i inner
function automatic void predict_survivors();
  longint ped;
  exp_n = 0;
  for (int k = 0; k < `KB_N_SURV; k++) begin
    exp_ped[k]  = 0;
    exp_info[k] = 0;
  end
  for (int p = 0; p < `KB_N_PARENT; p++) begin
    slice_row(0, st_y1 - st_ihi[p], st_r11);
    slice_row(1, st_y2 - st_ilo[p], st_r22);
    for (int m = 0; m < `KB_N_CAND; m++) begin
      for (int i = 0; i < `KB_N_CAND; i++) begin
        ped = longint'(st_ped[p]) + longint'(mdl_err[0][m]) * mdl_err[0][m]
            + longint'(mdl_err[1][i]) * mdl_err[1][i];
        insert_child(ped, p * 64 + mdl_code[0][m] * 8 + mdl_code[1][i]);
      end
    end
  end
endfunction

`endif

/* verification/kbest_tb.sv */
`timescale 1ns/1ps
`include "kbest_consts.svh"

module kbest_tb;

  typedef logic [`KB_ADR_W-1:0] adr_t;

  // 20 random runs plus three directed, each 70 busy cycles and up to 40 bus words
  localparam int N_RUNS     = 20;
  localparam int MAX_CYCLES = (N_RUNS + 3) * (70 + 2 * 40) + 1000;

  logic               clk;
  logic               rst;
  kbest_pkg::wb_req_t wb_i;
  kbest_pkg::wb_rsp_t wb_o;

  int cycle = 0;
  int start_cycle;
  int checks;
  int test_errs;
  int total_errs;
  int tests_passed;
  int tests_failed;

  // stimulus of the current run
  int st_y1;
  int st_y2;
  int st_r11;
  int st_r22;
  int st_ped [`KB_N_PARENT];
  int st_ihi [`KB_N_PARENT];
  int st_ilo [`KB_N_PARENT];

  `include "kbest_ref_model.svh"

  kbest_layer_top dut (
    .clk  (clk),
    .rst  (rst),
    .wb_i (wb_i),
    .wb_o (wb_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout, run still going after %0d cycles", cycle);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // called on a falling edge, one idle cycle after the ack
  task automatic bus_write(input adr_t adr, input logic [31:0] dat);
    wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    @(negedge clk);
    while (!wb_o.ack)
      @(negedge clk);
    wb_i = '0;
    @(negedge clk);
  endtask

  task automatic bus_read(input adr_t adr, output logic [31:0] dat);
    wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    @(negedge clk);
    while (!wb_o.ack)
      @(negedge clk);
    dat  = wb_o.dat;
    wb_i = '0;
    @(negedge clk);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %-10s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    if (test_errs == 0)
      tests_passed++;
    else
      tests_failed++;
    total_errs += test_errs;
    test_errs   = 0;
  endtask

  // ranges keep every ped inside 32 bits
  task automatic randomize_stim();
    st_y1  = int'($urandom_range(4094)) - 2047;
    st_y2  = int'($urandom_range(4094)) - 2047;
    st_r11 = int'($urandom_range(255, 1));
    st_r22 = int'($urandom_range(255, 1));
    for (int p = 0; p < `KB_N_PARENT; p++) begin
      st_ped[p] = int'($urandom_range(2 ** 27 - 1));
      st_ihi[p] = int'($urandom_range(4094)) - 2047;
      st_ilo[p] = int'($urandom_range(4094)) - 2047;
    end
  endtask

  task automatic load_run();
    bus_write(`KB_ADR_Y1, st_y1);
    bus_write(`KB_ADR_Y2, st_y2);
    bus_write(`KB_ADR_R11, st_r11);
    bus_write(`KB_ADR_R22, st_r22);
    for (int p = 0; p < `KB_N_PARENT; p++) begin
      bus_write(adr_t'(`KB_ADR_PARENT + 3 * p), st_ped[p]);
      bus_write(adr_t'(`KB_ADR_PARENT + 3 * p + 1), st_ihi[p]);
      bus_write(adr_t'(`KB_ADR_PARENT + 3 * p + 2), st_ilo[p]);
    end
  endtask

  // start_cycle marks the edge that acked the start write
  task automatic start_run();
    bus_write(`KB_ADR_CTRL, 32'h1);
    start_cycle = cycle - 1;
  endtask

  task automatic wait_done(output int elapsed, output logic [31:0] status);
    status = '0;
    while (!status[1])
      bus_read(`KB_ADR_CTRL, status);
    elapsed = cycle - start_cycle;
  endtask

  task automatic check_results();
    logic [31:0] rd;
    for (int s = 0; s < `KB_N_SURV; s++) begin
      bus_read(adr_t'(`KB_ADR_RESULT + 2 * s), rd);
      check_eq($sformatf("surv[%0d].ped", s), rd, exp_ped[s][31:0]);
      bus_read(adr_t'(`KB_ADR_RESULT + 2 * s + 1), rd);
      check_eq($sformatf("surv[%0d].info", s), rd, exp_info[s]);
    end
  endtask

  initial begin
    logic [31:0] rd;
    int          elapsed;
    clk  = 1'b0;
    rst  = 1'b1;
    wb_i = '0;
    void'($urandom(78));
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // idle status, empty list
    bus_read(`KB_ADR_CTRL, rd);
    check_eq("ctrl", rd, 32'h0);
    for (int w = 0; w < 2 * `KB_N_SURV; w++) begin
      bus_read(adr_t'(`KB_ADR_RESULT + w), rd);
      check_eq($sformatf("result[%0d]", w), rd, 32'h0);
    end
    finish_test("reset");

    // register readback, sign extended samples
    randomize_stim();
    load_run();
    bus_read(`KB_ADR_Y1, rd);
    check_eq("y1", rd, st_y1);
    bus_read(`KB_ADR_Y2, rd);
    check_eq("y2", rd, st_y2);
    bus_read(`KB_ADR_R11, rd);
    check_eq("r11", rd, st_r11);
    bus_read(`KB_ADR_R22, rd);
    check_eq("r22", rd, st_r22);
    for (int p = 0; p < `KB_N_PARENT; p++) begin
      bus_read(adr_t'(`KB_ADR_PARENT + 3 * p), rd);
      check_eq($sformatf("parent[%0d].ped", p), rd, st_ped[p]);
      bus_read(adr_t'(`KB_ADR_PARENT + 3 * p + 1), rd);
      check_eq($sformatf("parent[%0d].isum_hi", p), rd, st_ihi[p]);
      bus_read(adr_t'(`KB_ADR_PARENT + 3 * p + 2), rd);
      check_eq($sformatf("parent[%0d].isum_lo", p), rd, st_ilo[p]);
    end
    // holes in the map
    bus_read(adr_t'(5), rd);
    check_eq("unmapped[5]", rd, 32'h0);
    bus_read(adr_t'(20), rd);
    check_eq("unmapped[20]", rd, 32'h0);
    bus_read(adr_t'(63), rd);
    check_eq("unmapped[63]", rd, 32'h0);
    finish_test("readback");

    // restart midway would push done far past 70 cycles
    predict_survivors();
    start_run();
    bus_read(`KB_ADR_CTRL, rd);
    check_eq("ctrl.busy", rd, 32'h1);
    repeat (20) @(negedge clk);
    bus_write(`KB_ADR_CTRL, 32'h1);
    bus_read(`KB_ADR_CTRL, rd);
    check_eq("ctrl.busy", rd, 32'h1);
    wait_done(elapsed, rd);
    check_eq("ctrl.done", rd, 32'h2);
    checks++;
    assert (elapsed >= 70 && elapsed <= 75) else begin
      $display("done seen %0d cycles after start, expected 70 to 75", elapsed);
      test_errs++;
    end
    check_results();
    finish_test("start_busy");

    for (int r = 0; r < N_RUNS; r++) begin
      randomize_stim();
      load_run();
      predict_survivors();
      start_run();
      wait_done(elapsed, rd);
      check_results();
    end
    finish_test("random");

    // y on a level midpoint gives equal errors, identical parents give equal peds
    st_y1  = 0;
    st_y2  = 0;
    st_r11 = 10;
    st_r22 = 20;
    for (int p = 0; p < `KB_N_PARENT; p++) begin
      st_ped[p] = 1000;
      st_ihi[p] = 0;
      st_ilo[p] = 0;
    end
    load_run();
    predict_survivors();
    start_run();
    bus_write(`KB_ADR_Y1, 32'd500);
    bus_write(`KB_ADR_PARENT, 32'd0);
    wait_done(elapsed, rd);
    check_results();
    bus_read(`KB_ADR_Y1, rd);
    check_eq("y1", rd, 32'd0);
    bus_read(`KB_ADR_PARENT, rd);
    check_eq("parent[0].ped", rd, 32'd1000);
    finish_test("ties");

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, total_errs);
    if (total_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
